// File: alu/int_alu.sv
`timescale 1ns/1ps
`include "exec_int_cfg.svh"

module int_alu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_valid,
    input  exec_int_pkg::alu_op_e i_alu_op,
    input  logic                  i_illegal,
    input  exec_int_pkg::xlen_t   i_operand_a,
    input  exec_int_pkg::xlen_t   i_operand_b,
    output logic                  o_valid,
    output logic                  o_illegal,
    output exec_int_pkg::xlen_t   o_result
);
    import exec_int_pkg::*;

    logic [`SHAMT_W-1:0] shamt;
    logic                lt_signed;
    logic                lt_unsigned;
    xlen_t               alu_result;

    assign shamt       = i_operand_b[`SHAMT_W-1:0];
    assign lt_signed   = $signed(i_operand_a) < $signed(i_operand_b);
    assign lt_unsigned = i_operand_a < i_operand_b;

    always_comb begin
        case (i_alu_op)
            ALU_ADD:    alu_result = i_operand_a + i_operand_b;
            ALU_SUB:    alu_result = i_operand_a - i_operand_b;
            ALU_SLL:    alu_result = i_operand_a << shamt;
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    alu_result = i_operand_a ^ i_operand_b;
            ALU_SRL:    alu_result = i_operand_a >> shamt;
            ALU_SRA:    alu_result = $signed(i_operand_a) >>> shamt; // Fills with sign bit
            ALU_OR:     alu_result = i_operand_a | i_operand_b;
            ALU_AND:    alu_result = i_operand_a & i_operand_b;
            ALU_PASS_B: alu_result = i_operand_b; // LUI
            default:    alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid   <= 1'b0;
            o_illegal <= 1'b0;
        end else begin
            o_valid   <= i_valid;
            o_illegal <= i_valid && i_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_result <= i_illegal ? '0 : alu_result; // Trapped ops return 0
        end
    end

endmodule

// File: common/exec_int_cfg.svh
`ifndef EXEC_INT_CFG_SVH
`define EXEC_INT_CFG_SVH

// Data word width
`define XLEN 64

// Operand width of one partial product
`define HALF_W 32

`define SHAMT_W 6

// Immediate fields as they come out of decode
`define IIMM_W 12
`define UIMM_W 20

`define EXEC_LATENCY 2

`endif

// File: common/exec_int_pkg.sv
`include "exec_int_cfg.svh"

package exec_int_pkg;

    typedef logic [`XLEN-1:0] xlen_t;

    // Major opcode, instruction bits [6:2]
    typedef enum logic [4:0] {
        OPC_OP_IMM    = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_OP_IMM_32 = 5'b00110, // W forms decode as illegal
        OPC_OP        = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_OP_32     = 5'b01110
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Same order as funct3[1:0] of the multiply group
    typedef enum logic [1:0] {
        MUL_LO  = 2'd0,
        MUL_HSS = 2'd1,
        MUL_HSU = 2'd2,
        MUL_HUU = 2'd3
    } mul_op_e;

    typedef enum logic [3:0] {
        TRAP_NONE         = 4'd0,
        EXC_ILLEGAL_INSTR = 4'd2
    } trap_cause_e;

endpackage

// File: logic/exec_int.sv
`timescale 1ns/1ps
`include "exec_int_cfg.svh"

module exec_int (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_valid,
    input  exec_int_pkg::opcode_e     i_opcode,
    input  logic [2:0]                i_funct3,
    input  logic [6:0]                i_funct7,
    input  logic [`IIMM_W-1:0]        i_i_imm,
    input  logic [`UIMM_W-1:0]        i_u_imm,
    input  exec_int_pkg::xlen_t       i_pc,
    input  exec_int_pkg::xlen_t       i_rs1_data,
    input  exec_int_pkg::xlen_t       i_rs2_data,
    output logic                      o_valid,
    output logic                      o_exception,
    output exec_int_pkg::trap_cause_e o_trap_cause,
    output exec_int_pkg::xlen_t       o_result
);

    logic                  alu_valid;
    logic                  mul_valid;
    exec_int_pkg::alu_op_e alu_op;
    exec_int_pkg::mul_op_e mul_op;
    logic                  illegal;
    exec_int_pkg::xlen_t   operand_a;
    exec_int_pkg::xlen_t   operand_b;

    // Stage 1 outputs
    logic                  s1_alu_valid;
    logic                  s1_alu_illegal;
    exec_int_pkg::xlen_t   s1_alu_result;
    logic                  s1_mul_valid;
    exec_int_pkg::xlen_t   s1_mul_result;

    int_decode u_decode (
        .i_valid     (i_valid),
        .i_opcode    (i_opcode),
        .i_funct3    (i_funct3),
        .i_funct7    (i_funct7),
        .i_i_imm     (i_i_imm),
        .i_u_imm     (i_u_imm),
        .i_pc        (i_pc),
        .i_rs1_data  (i_rs1_data),
        .i_rs2_data  (i_rs2_data),
        .o_alu_valid (alu_valid),
        .o_mul_valid (mul_valid),
        .o_alu_op    (alu_op),
        .o_mul_op    (mul_op),
        .o_illegal   (illegal),
        .o_operand_a (operand_a),
        .o_operand_b (operand_b)
    );

    int_alu u_alu (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (alu_valid),
        .i_alu_op    (alu_op),
        .i_illegal   (illegal),
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .o_valid     (s1_alu_valid),
        .o_illegal   (s1_alu_illegal),
        .o_result    (s1_alu_result)
    );

    int_mul u_mul (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (mul_valid),
        .i_mul_op   (mul_op),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_valid    (s1_mul_valid),
        .o_result   (s1_mul_result)
    );

    int_result_stage u_result (
        .clk           (clk),
        .rst           (rst),
        .i_alu_valid   (s1_alu_valid),
        .i_alu_illegal (s1_alu_illegal),
        .i_alu_result  (s1_alu_result),
        .i_mul_valid   (s1_mul_valid),
        .i_mul_result  (s1_mul_result),
        .o_valid       (o_valid),
        .o_exception   (o_exception),
        .o_trap_cause  (o_trap_cause),
        .o_result      (o_result)
    );

endmodule

// File: logic/int_decode.sv
`timescale 1ns/1ps
`include "exec_int_cfg.svh"

module int_decode (
    input  logic                  i_valid,
    input  exec_int_pkg::opcode_e i_opcode,
    input  logic [2:0]            i_funct3,
    input  logic [6:0]            i_funct7,
    input  logic [`IIMM_W-1:0]    i_i_imm,
    input  logic [`UIMM_W-1:0]    i_u_imm,
    input  exec_int_pkg::xlen_t   i_pc,
    input  exec_int_pkg::xlen_t   i_rs1_data,
    input  exec_int_pkg::xlen_t   i_rs2_data,
    output logic                  o_alu_valid,
    output logic                  o_mul_valid,
    output exec_int_pkg::alu_op_e o_alu_op,
    output exec_int_pkg::mul_op_e o_mul_op,
    output logic                  o_illegal,
    output exec_int_pkg::xlen_t   o_operand_a,
    output exec_int_pkg::xlen_t   o_operand_b
);
    import exec_int_pkg::*;

    xlen_t imm_i_sext;
    xlen_t imm_u_sext;
    logic  is_mul;

    // Shared funct3 table of OP and OP_IMM, alt picks SUB or SRA
    function automatic alu_op_e alu_from_funct3(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign imm_i_sext = {{(`XLEN-`IIMM_W){i_i_imm[`IIMM_W-1]}}, i_i_imm};
    assign imm_u_sext = {{(`XLEN-`UIMM_W-`IIMM_W){i_u_imm[`UIMM_W-1]}}, i_u_imm, {`IIMM_W{1'b0}}};

    always_comb begin
        o_alu_op  = ALU_ADD;
        o_illegal = 1'b0;
        is_mul    = 1'b0;
        case (i_opcode)
            OPC_LUI:   o_alu_op = ALU_PASS_B;
            OPC_AUIPC: o_alu_op = ALU_ADD;
            OPC_OP_IMM: begin
                // imm[10] is only an opcode bit for the right shifts
                o_alu_op = alu_from_funct3(i_funct3, i_funct3 == 3'b101 && i_i_imm[10]);
                if (i_funct3 == 3'b001) begin
                    o_illegal = i_i_imm[11:6] != '0;
                end else if (i_funct3 == 3'b101) begin
                    o_illegal = i_i_imm[11] || i_i_imm[9:6] != '0;
                end
            end
            OPC_OP: begin
                if (i_funct7 == 7'h01) begin
                    is_mul    = !i_funct3[2];
                    o_illegal = i_funct3[2]; // No divider
                end else if (i_funct7 == 7'h00) begin
                    o_alu_op = alu_from_funct3(i_funct3, 1'b0);
                end else if (i_funct7 == 7'h20) begin
                    o_alu_op  = alu_from_funct3(i_funct3, 1'b1);
                    o_illegal = i_funct3 != 3'b000 && i_funct3 != 3'b101;
                end else begin
                    o_illegal = 1'b1;
                end
            end
            default: o_illegal = 1'b1; // W forms and unknown opcodes
        endcase
    end

    always_comb begin
        case (i_funct3[1:0])
            2'b00:   o_mul_op = MUL_LO;
            2'b01:   o_mul_op = MUL_HSS;
            2'b10:   o_mul_op = MUL_HSU;
            default: o_mul_op = MUL_HUU;
        endcase
    end

    assign o_alu_valid = i_valid && !is_mul;
    assign o_mul_valid = i_valid && is_mul;

    assign o_operand_a = (i_opcode == OPC_AUIPC) ? i_pc : i_rs1_data;

    always_comb begin
        case (i_opcode)
            OPC_LUI, OPC_AUIPC: o_operand_b = imm_u_sext;
            OPC_OP_IMM:         o_operand_b = imm_i_sext;
            default:            o_operand_b = i_rs2_data;
        endcase
    end

endmodule

// File: logic/int_result_stage.sv
`timescale 1ns/1ps

module int_result_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_alu_valid,
    input  logic                      i_alu_illegal,
    input  exec_int_pkg::xlen_t       i_alu_result,
    input  logic                      i_mul_valid,
    input  exec_int_pkg::xlen_t       i_mul_result,
    output logic                      o_valid,
    output logic                      o_exception,
    output exec_int_pkg::trap_cause_e o_trap_cause,
    output exec_int_pkg::xlen_t       o_result
);
    import exec_int_pkg::*;

    logic trap;

    assign trap = i_alu_valid && i_alu_illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid      <= 1'b0;
            o_exception  <= 1'b0;
            o_trap_cause <= TRAP_NONE;
        end else begin
            o_valid      <= i_alu_valid || i_mul_valid;
            o_exception  <= trap;
            o_trap_cause <= trap ? EXC_ILLEGAL_INSTR : TRAP_NONE;
        end
    end

    // Only one path is valid per cycle
    always_ff @(posedge clk) begin
        if (i_mul_valid) begin
            o_result <= i_mul_result;
        end else if (i_alu_valid) begin
            o_result <= i_alu_result;
        end
    end

endmodule

// File: mul/int_mul.sv
`timescale 1ns/1ps
`include "exec_int_cfg.svh"

module int_mul (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_valid,
    input  exec_int_pkg::mul_op_e i_mul_op,
    input  exec_int_pkg::xlen_t   i_rs1_data,
    input  exec_int_pkg::xlen_t   i_rs2_data,
    output logic                  o_valid,
    output exec_int_pkg::xlen_t   o_result
);
    import exec_int_pkg::*;

    logic               rs1_signed;
    logic               rs2_signed;
    xlen_t              pp_ll;
    xlen_t              pp_lh;
    xlen_t              pp_hl;
    xlen_t              pp_hh;
    xlen_t              hi_corr;
    mul_op_e            op_q;
    logic [2*`XLEN-1:0] sum_low;
    logic [2*`XLEN-1:0] product;

    assign rs1_signed = (i_mul_op == MUL_HSS) || (i_mul_op == MUL_HSU);
    assign rs2_signed = (i_mul_op == MUL_HSS);

    always_ff @(posedge clk) begin
        if (i_valid) begin
            pp_ll <= i_rs1_data[`HALF_W-1:0] * i_rs2_data[`HALF_W-1:0];
            pp_lh <= i_rs1_data[`HALF_W-1:0] * i_rs2_data[`XLEN-1:`HALF_W];
            pp_hl <= i_rs1_data[`XLEN-1:`HALF_W] * i_rs2_data[`HALF_W-1:0];
            pp_hh <= i_rs1_data[`XLEN-1:`HALF_W] * i_rs2_data[`XLEN-1:`HALF_W];
            // A negative signed operand subtracts the other one from the high word
            hi_corr <= ((rs1_signed && i_rs1_data[`XLEN-1]) ? -i_rs2_data : '0)
                     + ((rs2_signed && i_rs2_data[`XLEN-1]) ? -i_rs1_data : '0);
            op_q <= i_mul_op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Unsigned 128-bit product of the partial products
    assign sum_low = {{`XLEN{1'b0}}, pp_ll}
                   + {{`HALF_W{1'b0}}, pp_lh, {`HALF_W{1'b0}}}
                   + {{`HALF_W{1'b0}}, pp_hl, {`HALF_W{1'b0}}}
                   + {pp_hh, {`XLEN{1'b0}}};

    assign product  = {sum_low[2*`XLEN-1:`XLEN] + hi_corr, sum_low[`XLEN-1:0]};
    assign o_result = (op_q == MUL_LO) ? product[`XLEN-1:0] : product[2*`XLEN-1:`XLEN];

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk; // 10 ns period
    end

endmodule

// File: test/exec_int_model.svh
`ifndef EXEC_INT_MODEL_SVH
`define EXEC_INT_MODEL_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[5:0];
        3'd2:    return ($signed(a) < $signed(b)) ? xlen_t'(1) : xlen_t'(0);
        3'd3:    return (a < b) ? xlen_t'(1) : xlen_t'(0);
        3'd4:    return a ^ b;
        3'd5:    return alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// Full 128-bit product of operands extended by their signedness
function automatic xlen_t mul_model(input logic [1:0] f2, input xlen_t a, input xlen_t b);
    logic [2*`XLEN-1:0] pa;
    logic [2*`XLEN-1:0] pb;
    logic [2*`XLEN-1:0] p;
    pa = {{`XLEN{(f2 == 2'd1 || f2 == 2'd2) && a[`XLEN-1]}}, a};
    pb = {{`XLEN{(f2 == 2'd1) && b[`XLEN-1]}}, b};
    p  = pa * pb;
    return (f2 == 2'd0) ? p[`XLEN-1:0] : p[2*`XLEN-1:`XLEN];
endfunction

// Returns {illegal, result}
function automatic logic [`XLEN:0] model_exec(input opcode_e opc, input logic [2:0] f3,
    input logic [6:0] f7, input logic [`IIMM_W-1:0] iimm, input logic [`UIMM_W-1:0] uimm,
    input xlen_t pc, input xlen_t rs1, input xlen_t rs2);
    xlen_t ival;
    xlen_t uval;
    ival = $signed(iimm);
    uval = $signed({uimm, 12'h000});
    if (opc == OPC_LUI) return {1'b0, uval};
    if (opc == OPC_AUIPC) return {1'b0, pc + uval};
    if (opc == OPC_OP_IMM) begin
        if (f3 == 3'd1 && iimm[11:6] != 6'd0) return {1'b1, `XLEN'd0};
        if (f3 == 3'd5 && (iimm[11] || iimm[9:6] != 4'd0)) return {1'b1, `XLEN'd0};
        return {1'b0, alu_model(f3, f3 == 3'd5 && iimm[10], rs1, ival)};
    end
    if (opc == OPC_OP) begin
        if (f7 == 7'h01 && !f3[2]) return {1'b0, mul_model(f3[1:0], rs1, rs2)};
        if (f7 == 7'h00) return {1'b0, alu_model(f3, 1'b0, rs1, rs2)};
        if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))
            return {1'b0, alu_model(f3, 1'b1, rs1, rs2)};
    end
    return {1'b1, `XLEN'd0}; // Reserved encodings, divider, W forms
endfunction

`endif

// File: test/tb_exec_int.sv
`timescale 1ns/1ps
`include "exec_int_cfg.svh"

module tb_exec_int;
    import exec_int_pkg::*;

    `include "exec_int_model.svh"

    localparam int NUM_TESTS = 3000;

    logic               clk;
    logic               rst;
    logic               i_valid;
    opcode_e            i_opcode;
    logic [2:0]         i_funct3;
    logic [6:0]         i_funct7;
    logic [`IIMM_W-1:0] i_i_imm;
    logic [`UIMM_W-1:0] i_u_imm;
    xlen_t              i_pc;
    xlen_t              i_rs1_data;
    xlen_t              i_rs2_data;
    logic               o_valid;
    logic               o_exception;
    trap_cause_e        o_trap_cause;
    xlen_t              o_result;

    logic [31:0] lfsr_state;
    xlen_t       exp_result_q[$];
    logic        exp_illegal_q[$];
    string       name_q[$];
    logic [1:0]  valid_hist;
    int          mismatch_errors;
    int          other_errors;

    tb_clock u_clock (.o_clk(clk));

    exec_int u_dut (
        .clk(clk), .rst(rst), .i_valid(i_valid), .i_opcode(i_opcode),
        .i_funct3(i_funct3), .i_funct7(i_funct7), .i_i_imm(i_i_imm), .i_u_imm(i_u_imm),
        .i_pc(i_pc), .i_rs1_data(i_rs1_data), .i_rs2_data(i_rs2_data),
        .o_valid(o_valid), .o_exception(o_exception), .o_trap_cause(o_trap_cause),
        .o_result(o_result)
    );

    function automatic xlen_t rand_bits(input int n);
        xlen_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[`XLEN-2:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic xlen_t pick_operand();
        case (rand_bits(3))
            0:       return '1;
            1:       return {1'b1, {(`XLEN-1){1'b0}}}; // Most negative
            2:       return rand_bits(6);
            default: return rand_bits(`XLEN);
        endcase
    endfunction

    task automatic check_result(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("Mismatch %s result: expected %h, actual %h", name, exp, act);
            mismatch_errors++;
        end
    endtask

    task automatic check_exception(input string name, input trap_cause_e exp_cause,
                                   input logic exp_exc, input trap_cause_e act_cause,
                                   input logic act_exc);
        if (act_exc !== exp_exc || act_cause !== exp_cause) begin
            $display("Mismatch %s exception: expected %b cause %0d, actual %b cause %0d",
                     name, exp_exc, exp_cause, act_exc, act_cause);
            mismatch_errors++;
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s o_valid: expected %b, actual %b", name, exp, act);
            mismatch_errors++;
        end
    endtask

    task automatic drive_random();
        logic [4:0]         raw_opc;
        opcode_e            opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [`IIMM_W-1:0] iimm;
        logic [`UIMM_W-1:0] uimm;
        xlen_t              pc;
        xlen_t              a;
        xlen_t              b;
        logic [`XLEN:0]     exp;
        string              name;
        if (rand_bits(2) == 0) begin
            i_valid <= 1'b0; // Idle cycle
            return;
        end
        f3   = rand_bits(3);
        f7   = 7'h00;
        iimm = rand_bits(`IIMM_W);
        uimm = rand_bits(`UIMM_W);
        pc   = rand_bits(`XLEN);
        a    = pick_operand();
        b    = pick_operand();
        case (rand_bits(4))
            0: begin
                opc  = OPC_LUI;
                name = "lui";
            end
            1: begin
                opc  = OPC_AUIPC;
                name = "auipc";
            end
            2, 3, 4: begin
                opc  = OPC_OP_IMM;
                name = "op_imm";
                if (rand_bits(3) != 0) begin
                    iimm[11]  = 1'b0; // Mostly legal shift immediates
                    iimm[9:6] = 4'd0;
                    if (f3 == 3'd1) iimm[10] = 1'b0;
                end
            end
            5, 6, 7, 8: begin
                opc  = OPC_OP;
                name = "op";
                f7   = rand_bits(1) ? 7'h20 : 7'h00;
            end
            9, 10, 11: begin
                opc  = OPC_OP;
                name = "mul";
                f7   = 7'h01;
            end
            12: begin
                opc  = OPC_OP;
                name = "op_funct7";
                f7   = rand_bits(7);
            end
            13: begin
                opc  = rand_bits(1) ? OPC_OP_32 : OPC_OP_IMM_32;
                name = "w_form";
            end
            default: begin
                raw_opc = rand_bits(5);
                opc     = opcode_e'(raw_opc);
                name    = "opcode";
            end
        endcase
        i_valid    <= 1'b1;
        i_opcode   <= opc;
        i_funct3   <= f3;
        i_funct7   <= f7;
        i_i_imm    <= iimm;
        i_u_imm    <= uimm;
        i_pc       <= pc;
        i_rs1_data <= a;
        i_rs2_data <= b;
        exp = model_exec(opc, f3, f7, iimm, uimm, pc, a, b);
        exp_result_q.push_back(exp[`XLEN-1:0]);
        exp_illegal_q.push_back(exp[`XLEN]);
        name_q.push_back(name);
    endtask

    // Sample outputs on the falling edge where they are stable
    always @(negedge clk) begin : monitor
        string name;
        logic  ill;
        xlen_t exp_r;
        if (!rst) begin
            check_valid("latency", valid_hist[1], o_valid);
            if (o_valid && exp_result_q.size() == 0) begin
                $display("Error: o_valid went high with no instruction outstanding");
                other_errors++;
            end else if (o_valid) begin
                name  = name_q.pop_front();
                ill   = exp_illegal_q.pop_front();
                exp_r = exp_result_q.pop_front();
                check_exception(name, ill ? EXC_ILLEGAL_INSTR : TRAP_NONE, ill,
                                o_trap_cause, o_exception);
                check_result(name, exp_r, o_result);
            end
        end
        valid_hist = {valid_hist[0], i_valid};
    end

    initial begin
        #((NUM_TESTS + 20) * 10 * 2);
        $display("Error: watchdog timeout, the test did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        lfsr_state      = 32'h878d32cd;
        mismatch_errors = 0;
        other_errors    = 0;
        valid_hist      = 2'b00;
        rst             = 1'b1;
        i_valid         = 1'b0;
        i_opcode        = OPC_OP;
        i_funct3        = '0;
        i_funct7        = '0;
        i_i_imm         = '0;
        i_u_imm         = '0;
        i_pc            = '0;
        i_rs1_data      = '0;
        i_rs2_data      = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (NUM_TESTS) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        i_valid <= 1'b0;
        repeat (`EXEC_LATENCY + 2) @(posedge clk);
        if (exp_result_q.size() != 0) begin
            $display("Error: %0d expected results were never returned", exp_result_q.size());
            other_errors++;
        end
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
+incdir+test
common/exec_int_pkg.sv
logic/int_decode.sv
alu/int_alu.sv
mul/int_mul.sv
logic/int_result_stage.sv
logic/exec_int.sv
test/tb_clock.sv
test/tb_exec_int.sv
